// ==== filelist.f ====
+incdir+source
+incdir+test
source/buffer_sum_pkg.sv
source/line_memory.sv
source/line_fetch.sv
source/sum_ctrl.sv
source/buffer_sum_top.sv
test/tb_buffer_sum.sv

// ==== test/tb_buffer_sum_tasks.svh ====
`ifndef TB_BUFFER_SUM_TASKS_SVH
`define TB_BUFFER_SUM_TASKS_SVH

// the model index of a byte address ignores its two low bits
function automatic int word_index(input logic [`BS_ADDR_W-1:0] addr);
	return int'(addr >> 2) % MODEL_WORDS;
endfunction

// wrapped sum of n model words starting at base
function automatic logic [`BS_WORD_W-1:0] model_sum(input logic [`BS_ADDR_W-1:0] base,
		input int n);
	logic [`BS_WORD_W-1:0] acc;
	acc = '0;
	for (int i = 0; i < n; i++) begin
		acc = acc + model_mem[word_index(base + `BS_ADDR_W'(4 * i))];
	end
	return acc;
endfunction

task automatic check_value(input string name, input logic [`BS_WORD_W-1:0] got,
		input logic [`BS_WORD_W-1:0] exp);
	check_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

// drives land and outputs are sampled 2 ns after a rising edge
task automatic next_cycle();
	@(posedge clk);
	#2;
endtask

task automatic report_test(input string name, input int err_before);
	test_cnt++;
	$display("test %0d %s: %s", test_cnt, name, (err_cnt == err_before) ? "ok" : "errors");
endtask

// a host write lasts one cycle and the model follows the port rules
task automatic host_write(input buffer_sum_pkg::host_cmd_e cmd,
		input logic [`BS_ADDR_W-1:0] addr, input logic [`BS_WORD_W-1:0] data);
	int idx;
	idx = word_index(addr);
	host_req = '{cmd: cmd, addr: addr, data: data};
	next_cycle();
	host_req.cmd = buffer_sum_pkg::NOP;
	if (cmd == buffer_sum_pkg::WRITE_BYTE) begin
		model_mem[idx][8 * addr[1:0] +: 8] = data[7:0];
	end else begin
		model_mem[idx] = data;
	end
endtask

// read data is registered, so it is there one edge after the command
task automatic host_read(input logic [`BS_ADDR_W-1:0] addr,
		output logic [`BS_WORD_W-1:0] data);
	host_req = '{cmd: buffer_sum_pkg::READ_WORD, addr: addr, data: '0};
	next_cycle();
	host_req.cmd = buffer_sum_pkg::NOP;
	data = host_rdata;
endtask

task automatic read_check(input logic [`BS_ADDR_W-1:0] addr);
	logic [`BS_WORD_W-1:0] rdata;
	host_read(addr, rdata);
	check_value("host_rdata_o", rdata, model_mem[word_index(addr)]);
endtask

// one engine run that may carry a second start which must be ignored
task automatic run_engine(input logic [`BS_ADDR_W-1:0] base, input int n,
		input logic [`BS_ADDR_W-1:0] dest, input bit stray_start);
	logic [`BS_WORD_W-1:0] expected;
	logic [`BS_WORD_W-1:0] rdata;
	int waited;
	expected = model_sum(base, n);
	start = 1'b1;
	base_addr = base;
	count = `BS_COUNT_W'(n);
	dest_addr = dest;
	next_cycle();
	start = 1'b0;
	waited = 0;
	// one word per cycle plus a few cycles of line latency and write back
	while (done !== 1'b1 && waited < n + 40) begin
		check_value("busy_o", busy, 1);
		start = stray_start && (waited == 2);
		if (start) begin
			base_addr = base + `BS_ADDR_W'(4);
			count = `BS_COUNT_W'(3);
			dest_addr = dest + `BS_ADDR_W'('h100);
		end
		next_cycle();
		waited++;
	end
	start = 1'b0;
	if (done !== 1'b1) begin
		err_cnt++;
		$display("done_o did not arrive within %0d cycles of the start at base %h", waited, base);
	end else begin
		check_value("sum_o", total, expected);
		next_cycle();
		// done is a single pulse and the total stays put afterwards
		check_value("done_o", done, 0);
		check_value("busy_o", busy, 0);
		check_value("sum_o", total, expected);
		model_mem[word_index(dest)] = expected;
		host_read(dest, rdata);
		check_value("host_rdata_o", rdata, expected);
	end
endtask

task automatic test_reset_host();
	int err_before;
	err_before = err_cnt;
	check_value("busy_o", busy, 0);
	check_value("done_o", done, 0);
	check_value("sum_o", total, 0);
	for (int i = 0; i < 6; i++) begin
		host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h100 + 4 * i), $urandom);
	end
	// a word write with its low address bits set still hits the whole word
	host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h113), 32'h1234_5678);
	host_write(buffer_sum_pkg::WRITE_BYTE, `BS_ADDR_W'('h105), 32'h0000_00a5);
	host_write(buffer_sum_pkg::WRITE_BYTE, `BS_ADDR_W'('h10b), 32'hffff_ff3c);
	for (int i = 0; i < 6; i++) begin
		read_check(`BS_ADDR_W'('h100 + 4 * i));
	end
	report_test("reset and host port", err_before);
endtask

task automatic test_aligned_buffer();
	int err_before;
	int pattern [8] = '{6, 3, 5, 4, 8, 2, 1, 3};
	err_before = err_cnt;
	for (int i = 0; i < 128; i++) begin
		host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('ha000 + 4 * i), pattern[i % 8]);
	end
	run_engine(`BS_ADDR_W'('ha000), 128, `BS_ADDR_W'('hb000), 1'b0);
	report_test("aligned buffer", err_before);
endtask

task automatic test_unaligned_ranges();
	int err_before;
	int n;
	logic [`BS_ADDR_W-1:0] base;
	err_before = err_cnt;
	for (int i = 0; i < 48; i++) begin
		host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h2000 + 4 * i), $urandom);
	end
	for (int r = 0; r < 16; r++) begin
		base = `BS_ADDR_W'('h2004 + 4 * ($urandom % 32));
		n = 1 + $urandom % 9;
		run_engine(base, n, `BS_ADDR_W'('h3000 + 4 * r), 1'b0);
		// the neighbours of the range hold data and must stay untouched
		read_check(base - `BS_ADDR_W'(4));
		read_check(base + `BS_ADDR_W'(4 * n));
	end
	report_test("unaligned ranges", err_before);
endtask

task automatic test_edge_counts();
	int err_before;
	err_before = err_cnt;
	host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h4800), 32'hdead_beef);
	run_engine(`BS_ADDR_W'('h4000), 0, `BS_ADDR_W'('h4800), 1'b0);
	host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h4008), 32'hffff_ffff);
	host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h400c), 32'hffff_fffe);
	host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h4010), 32'h8000_0000);
	host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h4014), 32'h8000_0005);
	host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h4018), 32'h0000_0003);
	run_engine(`BS_ADDR_W'('h4008), 5, `BS_ADDR_W'('h4804), 1'b0);
	report_test("edge counts", err_before);
endtask

task automatic test_ignored_start();
	int err_before;
	err_before = err_cnt;
	for (int i = 0; i < 16; i++) begin
		host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h5000 + 4 * i), $urandom);
	end
	// marker where the ignored start would have written its total
	host_write(buffer_sum_pkg::WRITE_WORD, `BS_ADDR_W'('h5900), 32'h5a5a_5a5a);
	run_engine(`BS_ADDR_W'('h5000), 16, `BS_ADDR_W'('h5800), 1'b1);
	read_check(`BS_ADDR_W'('h5900));
	report_test("ignored start", err_before);
endtask

`endif

// ==== test/tb_buffer_sum.sv ====
`timescale 1ns/1ps
`include "buffer_sum_cfg.svh"

module tb_buffer_sum;

	// the largest test needs under a thousand cycles, this leaves a wide margin
	localparam int CYCLE_LIMIT = 20000;
	// the DUT memory wraps at this many words and so does the model
	localparam int MODEL_WORDS = `BS_MEM_LINES * (`BS_LINE_W / `BS_WORD_W);

	logic                      clk;
	logic                      arst_n;
	buffer_sum_pkg::host_req_t host_req;
	logic [`BS_WORD_W-1:0]     host_rdata;
	logic                      start;
	logic [`BS_ADDR_W-1:0]     base_addr;
	logic [`BS_COUNT_W-1:0]    count;
	logic [`BS_ADDR_W-1:0]     dest_addr;
	logic                      busy;
	logic                      done;
	logic [`BS_WORD_W-1:0]     total;

	// expected memory contents, one entry per word, written along with the host
	logic [`BS_WORD_W-1:0] model_mem [MODEL_WORDS];

	int cycle_cnt = 0;
	int err_cnt   = 0;
	int check_cnt = 0;
	int test_cnt  = 0;

	buffer_sum_top buffer_sum_top_inst (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.host_req_i   (host_req),
		.host_rdata_o (host_rdata),
		.start_i      (start),
		.base_addr_i  (base_addr),
		.count_i      (count),
		.dest_addr_i  (dest_addr),
		.busy_o       (busy),
		.done_o       (done),
		.sum_o        (total)
	);

	always #20 clk = ~clk;

	// hard stop in case the engine or a wait loop never finishes
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles before the tests were finished", cycle_cnt);
			$display("TB FAILED");
			$finish;
		end
	end

	`include "tb_buffer_sum_tasks.svh"

	initial begin
		void'($urandom(32'h9464_fbdc));
		clk       = 1'b0;
		arst_n    = 1'b1;
		host_req  = '{cmd: buffer_sum_pkg::NOP, addr: '0, data: '0};
		start     = 1'b0;
		base_addr = '0;
		count     = '0;
		dest_addr = '0;
		// a real falling edge so every asynchronous reset flop sees it
		#1;
		arst_n = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;

		test_reset_host();
		test_aligned_buffer();
		test_unaligned_ranges();
		test_edge_counts();
		test_ignored_start();

		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== source/buffer_sum_top.sv ====
`timescale 1ns/1ps
`include "buffer_sum_cfg.svh"

module buffer_sum_top (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  buffer_sum_pkg::host_req_t host_req_i,
	output logic [`BS_WORD_W-1:0]     host_rdata_o,
	input  logic                      start_i,
	input  logic [`BS_ADDR_W-1:0]     base_addr_i,
	input  logic [`BS_COUNT_W-1:0]    count_i,
	input  logic [`BS_ADDR_W-1:0]     dest_addr_i,
	output logic                      busy_o,
	output logic                      done_o,
	output logic [`BS_WORD_W-1:0]     sum_o
);

	// fetch unit to memory and back
	buffer_sum_pkg::line_req_t line_req;
	buffer_sum_pkg::line_rsp_t line_rsp;
	// controller write of the total
	buffer_sum_pkg::word_wr_t  word_wr;

	logic                  load;
	logic                  word_valid;
	logic [`BS_WORD_W-1:0] word;
	logic                  last;

	line_memory line_memory_inst (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.line_req_i   (line_req),
		.line_rsp_o   (line_rsp),
		.word_wr_i    (word_wr),
		.host_req_i   (host_req_i),
		.host_rdata_o (host_rdata_o)
	);

	// base and count are sampled by the fetch unit on the controller's load
	line_fetch line_fetch_inst (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.load_i       (load),
		.base_addr_i  (base_addr_i),
		.count_i      (count_i),
		.line_req_o   (line_req),
		.line_rsp_i   (line_rsp),
		.word_valid_o (word_valid),
		.word_o       (word),
		.last_o       (last)
	);

	sum_ctrl sum_ctrl_inst (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.start_i      (start_i),
		.dest_addr_i  (dest_addr_i),
		.word_valid_i (word_valid),
		.word_i       (word),
		.last_i       (last),
		.load_o       (load),
		.word_wr_o    (word_wr),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.sum_o        (sum_o)
	);

endmodule

// ==== source/sum_ctrl.sv ====
`timescale 1ns/1ps
`include "buffer_sum_cfg.svh"

module sum_ctrl (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     start_i,
	input  logic [`BS_ADDR_W-1:0]    dest_addr_i,
	input  logic                     word_valid_i,
	input  logic [`BS_WORD_W-1:0]    word_i,
	input  logic                     last_i,
	output logic                     load_o,
	output buffer_sum_pkg::word_wr_t word_wr_o,
	output logic                     busy_o,
	output logic                     done_o,
	output logic [`BS_WORD_W-1:0]    sum_o
);

	buffer_sum_pkg::sum_state_e state_q;
	buffer_sum_pkg::sum_state_e state_d;

	// destination of the total as taken at start
	logic [`BS_ADDR_W-1:0] dest_q;
	// the running total wraps at the word width
	logic [`BS_WORD_W-1:0] acc_q;

	// a start is only seen in IDLE and passes by in every other state
	assign load_o = (state_q == buffer_sum_pkg::IDLE) && start_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			buffer_sum_pkg::IDLE: begin
				if (start_i) begin
					state_d = buffer_sum_pkg::RUN;
				end
			end
			buffer_sum_pkg::RUN: begin
				// last comes with the final word, which is still added below
				if (last_i) begin
					state_d = buffer_sum_pkg::WRITE;
				end
			end
			buffer_sum_pkg::WRITE: begin
				state_d = buffer_sum_pkg::DONE;
			end
			buffer_sum_pkg::DONE: begin
				state_d = buffer_sum_pkg::IDLE;
			end
			default: begin
				state_d = buffer_sum_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= buffer_sum_pkg::IDLE;
			acc_q   <= '0;
		end else begin
			state_q <= state_d;
			if (load_o) begin
				acc_q <= '0;
			end else if ((state_q == buffer_sum_pkg::RUN) && word_valid_i) begin
				acc_q <= acc_q + word_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_o) begin
			dest_q <= dest_addr_i;
		end
	end

	// the total goes to memory as one word write in WRITE
	assign word_wr_o = '{
		en:   (state_q == buffer_sum_pkg::WRITE),
		addr: dest_q,
		data: acc_q
	};

	assign busy_o = (state_q != buffer_sum_pkg::IDLE);
	assign done_o = (state_q == buffer_sum_pkg::DONE);
	// sum_o keeps the total after done until the next start clears it
	assign sum_o  = acc_q;

	// the fetch unit only hands out words while a run is going on
	a_words_in_run: assert property (@(posedge clk) disable iff (!arst_n_i)
		word_valid_i |-> (state_q == buffer_sum_pkg::RUN))
		else $error("word strobe outside RUN");

endmodule

// ==== source/line_fetch.sv ====
`timescale 1ns/1ps
`include "buffer_sum_cfg.svh"

module line_fetch (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      load_i,
	input  logic [`BS_ADDR_W-1:0]     base_addr_i,
	input  logic [`BS_COUNT_W-1:0]    count_i,
	output buffer_sum_pkg::line_req_t line_req_o,
	input  buffer_sum_pkg::line_rsp_t line_rsp_i,
	output logic                      word_valid_o,
	output logic [`BS_WORD_W-1:0]     word_o,
	output logic                      last_o
);

	localparam int WORDS  = `BS_LINE_W / `BS_WORD_W;
	localparam int WB_W   = $clog2(`BS_WORD_W / 8);
	localparam int LANE_W = $clog2(WORDS);
	localparam int CNT_W  = LANE_W + 1;

	// request side, next word to ask for and words not yet asked for
	logic [`BS_ADDR_W-1:0]  req_addr_q;
	logic [`BS_COUNT_W-1:0] req_left_q;
	// wanted words in the line that is in flight
	logic [CNT_W-1:0]       rsp_cnt_q;
	// shift side, the line being handed out
	logic [`BS_LINE_W-1:0]  line_q;
	logic [LANE_W-1:0]      lane_q;
	logic [CNT_W-1:0]       left_q;
	logic                   zero_q;

	logic [LANE_W-1:0]      req_lane;
	logic [CNT_W-1:0]       room;
	logic [CNT_W-1:0]       n_req;
	logic [CNT_W-1:0]       left_nxt;
	logic                   issue;

	always_comb begin
		req_lane = req_addr_q[WB_W +: LANE_W];
		// a partial first line starts at req_lane, a partial last line is cut by the count
		room = CNT_W'(WORDS) - CNT_W'(req_lane);
		if (req_left_q < `BS_COUNT_W'(room)) begin
			n_req = CNT_W'(req_left_q);
		end else begin
			n_req = room;
		end
		if (line_rsp_i.ready) begin
			left_nxt = rsp_cnt_q;
		end else if (left_q != '0) begin
			left_nxt = left_q - 1'b1;
		end else begin
			left_nxt = '0;
		end
		// ask early enough that the answer lands as the shifter runs dry
		// with one-word lines this is the very cycle a response comes in
		issue = (req_left_q != '0) && (left_nxt <= CNT_W'(1));
	end

	assign line_req_o = '{rd: issue, addr: req_addr_q};

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_addr_q <= '0;
			req_left_q <= '0;
			rsp_cnt_q  <= '0;
			lane_q     <= '0;
			left_q     <= '0;
			zero_q     <= 1'b0;
		end else begin
			zero_q <= load_i && (count_i == '0);
			if (load_i) begin
				req_addr_q <= base_addr_i;
				req_left_q <= count_i;
			end else if (issue) begin
				req_addr_q <= req_addr_q + (`BS_ADDR_W'(n_req) << WB_W);
				req_left_q <= req_left_q - `BS_COUNT_W'(n_req);
				rsp_cnt_q  <= n_req;
			end
			left_q <= left_nxt;
			// the echoed address tells which lane the first wanted word sits in
			if (line_rsp_i.ready) begin
				lane_q <= line_rsp_i.addr[WB_W +: LANE_W];
			end else if (left_q != '0) begin
				lane_q <= lane_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_rsp_i.ready) begin
			line_q <= line_rsp_i.data;
		end
	end

	assign word_valid_o = (left_q != '0);
	assign word_o       = line_q[lane_q*`BS_WORD_W +: `BS_WORD_W];
	// an empty range still ends with a last pulse, just without a word
	assign last_o = zero_q ||
		((left_q == CNT_W'(1)) && (req_left_q == '0) && !line_rsp_i.ready);

	// the controller only reloads once the previous range is fully handed out
	a_no_load_while_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
		load_i |-> (req_left_q == '0) && (left_q == '0) && !line_rsp_i.ready)
		else $error("range loaded while words remain");

endmodule

// ==== source/line_memory.sv ====
`timescale 1ns/1ps
`include "buffer_sum_cfg.svh"

module line_memory (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  buffer_sum_pkg::line_req_t line_req_i,
	output buffer_sum_pkg::line_rsp_t line_rsp_o,
	input  buffer_sum_pkg::word_wr_t  word_wr_i,
	input  buffer_sum_pkg::host_req_t host_req_i,
	output logic [`BS_WORD_W-1:0]     host_rdata_o
);

	localparam int LINE_BYTES = `BS_LINE_W / 8;
	localparam int WORD_BYTES = `BS_WORD_W / 8;
	localparam int OFS_W      = $clog2(LINE_BYTES);
	localparam int WB_W       = $clog2(WORD_BYTES);
	localparam int LANE_W     = OFS_W - WB_W;
	localparam int IDX_W      = $clog2(`BS_MEM_LINES);
	// byte enables of word lane zero that get shifted up for the other lanes
	localparam logic [LINE_BYTES-1:0] WORD_BE = LINE_BYTES'((1 << WORD_BYTES) - 1);

	logic [`BS_LINE_W-1:0] mem_q [`BS_MEM_LINES];

	// the one write port is fed by the engine or the host
	logic [IDX_W-1:0]      wr_idx;
	logic [LINE_BYTES-1:0] wr_be;
	logic [`BS_LINE_W-1:0] wr_data;

	logic [IDX_W-1:0]      rd_idx;
	logic [IDX_W-1:0]      host_idx;
	logic [LANE_W-1:0]     host_lane;

	logic                  rsp_ready_q;
	logic [`BS_ADDR_W-1:0] rsp_addr_q;
	logic [`BS_LINE_W-1:0] rsp_data_q;
	logic [`BS_WORD_W-1:0] host_rdata_q;

	// byte enables for the word that holds addr
	function automatic logic [LINE_BYTES-1:0] word_be(input logic [`BS_ADDR_W-1:0] addr);
		logic [LANE_W-1:0] lane;
		lane = addr[WB_W +: LANE_W];
		return WORD_BE << (lane * WORD_BYTES);
	endfunction

	// lines are picked by the bits above the line offset
	assign rd_idx    = line_req_i.addr[OFS_W +: IDX_W];
	assign host_idx  = host_req_i.addr[OFS_W +: IDX_W];
	assign host_lane = host_req_i.addr[WB_W +: LANE_W];

	// the engine write goes first and a host write in the same cycle is dropped
	always_comb begin
		wr_idx  = host_idx;
		wr_be   = '0;
		wr_data = {(`BS_LINE_W / `BS_WORD_W){host_req_i.data}};
		if (word_wr_i.en) begin
			wr_idx  = word_wr_i.addr[OFS_W +: IDX_W];
			wr_be   = word_be(word_wr_i.addr);
			wr_data = {(`BS_LINE_W / `BS_WORD_W){word_wr_i.data}};
		end else if (host_req_i.cmd == buffer_sum_pkg::WRITE_WORD) begin
			// the two low address bits do not matter for a word write
			wr_be = word_be(host_req_i.addr);
		end else if (host_req_i.cmd == buffer_sum_pkg::WRITE_BYTE) begin
			wr_be   = LINE_BYTES'(1) << host_req_i.addr[OFS_W-1:0];
			wr_data = {LINE_BYTES{host_req_i.data[7:0]}};
		end
	end

	always_ff @(posedge clk) begin
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (wr_be[b]) begin
				mem_q[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
	end

	// read data sees the line as it was before a write in the same cycle
	always_ff @(posedge clk) begin
		if (line_req_i.rd) begin
			rsp_data_q <= mem_q[rd_idx];
			rsp_addr_q <= line_req_i.addr;
		end
		if (host_req_i.cmd == buffer_sum_pkg::READ_WORD) begin
			host_rdata_q <= mem_q[host_idx][host_lane*`BS_WORD_W +: `BS_WORD_W];
		end
	end

	// ready is the strobe delayed by one cycle and never stretches
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rsp_ready_q <= 1'b0;
		end else begin
			rsp_ready_q <= line_req_i.rd;
		end
	end

	assign line_rsp_o   = '{ready: rsp_ready_q, addr: rsp_addr_q, data: rsp_data_q};
	assign host_rdata_o = host_rdata_q;

	// engine traffic never points into the middle of a word
	a_engine_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
		(line_req_i.rd || word_wr_i.en) |->
		(line_req_i.rd ? line_req_i.addr[WB_W-1:0] : word_wr_i.addr[WB_W-1:0]) == '0)
		else $error("engine address not word aligned");

endmodule

// ==== source/buffer_sum_pkg.sv ====
`include "buffer_sum_cfg.svh"

package buffer_sum_pkg;

	// controller states
	// RUN lasts until the fetch unit flags its last word
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,
		WRITE = 2'd2,
		DONE  = 2'd3
	} sum_state_e;

	// host port commands, the host only talks to memory while the engine is idle
	typedef enum logic [1:0] {
		NOP        = 2'd0,
		WRITE_WORD = 2'd1,
		WRITE_BYTE = 2'd2,
		READ_WORD  = 2'd3
	} host_cmd_e;

	// line read request, a plain strobe with a byte address
	typedef struct packed {
		logic                  rd;
		logic [`BS_ADDR_W-1:0] addr;
	} line_req_t;

	// line response, ready is a single-cycle pulse and addr echoes the request
	typedef struct packed {
		logic                  ready;
		logic [`BS_ADDR_W-1:0] addr;
		logic [`BS_LINE_W-1:0] data;
	} line_rsp_t;

	// single word write from the engine
	typedef struct packed {
		logic                  en;
		logic [`BS_ADDR_W-1:0] addr;
		logic [`BS_WORD_W-1:0] data;
	} word_wr_t;

	// host access, data is only looked at for the two write commands
	typedef struct packed {
		host_cmd_e             cmd;
		logic [`BS_ADDR_W-1:0] addr;
		logic [`BS_WORD_W-1:0] data;
	} host_req_t;

endpackage

// ==== source/buffer_sum_cfg.svh ====
`ifndef BUFFER_SUM_CFG_SVH
`define BUFFER_SUM_CFG_SVH

// byte address width seen by the engine and the host
`define BS_ADDR_W 20

// one memory line is four 32-bit words
`define BS_LINE_W 128

// word width, which is also the width of the running total
`define BS_WORD_W 32

// lines held by the main memory
// any power of two works as long as the line index fits in the address
`define BS_MEM_LINES 4096

// width of the word count given with a start
`define BS_COUNT_W 16

`endif
